//--- verilog/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// byte address width of the fetch port and the AXI read address
`define ICACHE_ADDR_W 32

// one instruction word, also the AXI read data width
`define ICACHE_WORD_W 32

// words per cache line, so beats per refill burst
`define ICACHE_LINE_WORDS 4

// direct mapped, one line per index
`define ICACHE_LINES 16

`endif

//--- verilog/icache_pkg.sv
package icache_pkg;

    // four-phase front end
    typedef enum logic [1:0] {
        FETCH_IDLE   = 2'b00,  // wait for req
        FETCH_LOOKUP = 2'b01,  // address handed to the cache
        FETCH_ACK    = 2'b10,  // ack high, wait for req to fall
        FETCH_DROP   = 2'b11   // req seen low, ack released next
    } fetch_state_e;

    // cache control
    typedef enum logic [1:0] {
        CACHE_IDLE    = 2'b00,
        CACHE_COMPARE = 2'b01,
        CACHE_REFILL  = 2'b10,
        CACHE_RESPOND = 2'b11
    } cache_state_e;

    // AXI read channel machine
    typedef enum logic [1:0] {
        AXI_IDLE      = 2'b00,
        AXI_ADDR_WAIT = 2'b01,
        AXI_DATA_WAIT = 2'b11
    } axi_rd_state_e;

endpackage

//--- verilog/fetch_req_stage.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module fetch_req_stage (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      fetch_req_i,
    input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
    output logic                      fetch_ack_o,
    output logic [`ICACHE_WORD_W-1:0] fetch_data_o,
    output logic                      fetch_err_o,
    output logic                      lookup_valid_o,
    output logic [`ICACHE_ADDR_W-1:0] lookup_addr_o,
    input  logic                      lookup_ready_i,
    input  logic                      lookup_done_i,
    input  logic [`ICACHE_WORD_W-1:0] lookup_data_i,
    input  logic                      lookup_err_i
);
    import icache_pkg::*;

    localparam int BYTE_OFF_W = $clog2(`ICACHE_WORD_W / 8);

    fetch_state_e              state_q;
    logic                      sent_q;   // lookup accepted by the cache
    logic [`ICACHE_ADDR_W-1:0] addr_q;
    logic [`ICACHE_WORD_W-1:0] data_q;
    logic                      err_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= FETCH_IDLE;
            sent_q  <= 1'b0;
        end else begin
            case (state_q)
                FETCH_IDLE: begin
                    if (fetch_req_i) begin  // req rise
                        state_q <= FETCH_LOOKUP;
                        sent_q  <= 1'b0;
                    end
                end
                FETCH_LOOKUP: begin
                    if (lookup_valid_o && lookup_ready_i)
                        sent_q <= 1'b1;
                    if (lookup_done_i)
                        state_q <= FETCH_ACK;
                end
                FETCH_ACK: begin
                    if (!fetch_req_i)
                        state_q <= FETCH_DROP;  // requester let go
                end
                default: state_q <= FETCH_IDLE;  // ack falls here
            endcase
        end
    end

    // address and result payload
    always_ff @(posedge clock) begin
        if (state_q == FETCH_IDLE && fetch_req_i)
            addr_q <= {fetch_addr_i[`ICACHE_ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
        if (state_q == FETCH_LOOKUP && lookup_done_i) begin
            data_q <= lookup_data_i;  // held through the ack phase
            err_q  <= lookup_err_i;
        end
    end

    assign lookup_valid_o = (state_q == FETCH_LOOKUP) && !sent_q;
    assign lookup_addr_o  = addr_q;
    assign fetch_ack_o    = (state_q == FETCH_ACK) || (state_q == FETCH_DROP);
    assign fetch_data_o   = data_q;
    assign fetch_err_o    = err_q;

endmodule

//--- verilog/icache_core.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_core (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      lookup_valid_i,
    input  logic [`ICACHE_ADDR_W-1:0] lookup_addr_i,
    output logic                      lookup_ready_o,
    output logic                      lookup_done_o,
    output logic [`ICACHE_WORD_W-1:0] lookup_data_o,
    output logic                      lookup_err_o,
    output logic                      refill_req_o,
    output logic [`ICACHE_ADDR_W-1:0] refill_addr_o,
    input  logic                      refill_beat_valid_i,
    input  logic [`ICACHE_WORD_W-1:0] refill_beat_data_i,
    input  logic                      refill_last_i,
    input  logic                      refill_err_i
);
    import icache_pkg::*;

    localparam int BYTE_OFF_W = $clog2(`ICACHE_WORD_W / 8);
    localparam int WORD_OFF_W = $clog2(`ICACHE_LINE_WORDS);
    localparam int INDEX_W    = $clog2(`ICACHE_LINES);
    localparam int TAG_W      = `ICACHE_ADDR_W - INDEX_W - WORD_OFF_W - BYTE_OFF_W;
    localparam int LINE_OFF_W = WORD_OFF_W + BYTE_OFF_W;  // byte offset inside a line

    cache_state_e              state_q;
    logic [`ICACHE_ADDR_W-1:0] addr_q;      // address under lookup
    logic [WORD_OFF_W-1:0]     beat_cnt_q;  // next word to write during refill
    logic [`ICACHE_WORD_W-1:0] rdata_q;
    logic                      err_q;

    // arrays
    logic [`ICACHE_LINES-1:0]  valid_q;
    logic [TAG_W-1:0]          tag_mem  [0:`ICACHE_LINES-1];
    logic [`ICACHE_WORD_W-1:0] data_mem [0:`ICACHE_LINES*`ICACHE_LINE_WORDS-1];

    // address split
    logic [TAG_W-1:0]      addr_tag;
    logic [INDEX_W-1:0]    addr_idx;
    logic [WORD_OFF_W-1:0] addr_word;
    logic                  hit;

    assign addr_tag  = addr_q[`ICACHE_ADDR_W-1 -: TAG_W];
    assign addr_idx  = addr_q[LINE_OFF_W +: INDEX_W];
    assign addr_word = addr_q[BYTE_OFF_W +: WORD_OFF_W];

    assign hit = valid_q[addr_idx] && (tag_mem[addr_idx] == addr_tag);

    // control state and valid bits
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q    <= CACHE_IDLE;
            beat_cnt_q <= '0;
            valid_q    <= '0;  // whole cache empty
        end else begin
            case (state_q)
                CACHE_IDLE: begin
                    if (lookup_valid_i)
                        state_q <= CACHE_COMPARE;
                end
                CACHE_COMPARE: begin
                    if (hit) begin
                        state_q <= CACHE_RESPOND;
                    end else begin
                        state_q           <= CACHE_REFILL;
                        beat_cnt_q        <= '0;
                        valid_q[addr_idx] <= 1'b0;  // line gets overwritten
                    end
                end
                CACHE_REFILL: begin
                    if (refill_beat_valid_i) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (refill_last_i) begin
                            valid_q[addr_idx] <= !refill_err_i;  // bad burst leaves it invalid
                            state_q           <= CACHE_RESPOND;
                        end
                    end
                end
                default: state_q <= CACHE_IDLE;  // respond lasts one cycle
            endcase
        end
    end

    // address, arrays and result word
    always_ff @(posedge clock) begin
        if (state_q == CACHE_IDLE && lookup_valid_i)
            addr_q <= lookup_addr_i;
        if (state_q == CACHE_COMPARE && hit) begin
            rdata_q <= data_mem[{addr_idx, addr_word}];
            err_q   <= 1'b0;
        end
        if (state_q == CACHE_REFILL && refill_beat_valid_i) begin
            data_mem[{addr_idx, beat_cnt_q}] <= refill_beat_data_i;  // beats in address order
            if (beat_cnt_q == addr_word)
                rdata_q <= refill_beat_data_i;  // requested word passes by
            if (refill_last_i) begin
                tag_mem[addr_idx] <= addr_tag;
                err_q             <= refill_err_i;
            end
        end
    end

    assign lookup_ready_o = (state_q == CACHE_IDLE);
    assign lookup_done_o  = (state_q == CACHE_RESPOND);  // one cycle pulse
    assign lookup_data_o  = rdata_q;
    assign lookup_err_o   = err_q;

    // one pulse per miss, line aligned
    assign refill_req_o  = (state_q == CACHE_COMPARE) && !hit;
    assign refill_addr_o = {addr_q[`ICACHE_ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

endmodule

//--- verilog/axi_icache.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module axi_icache (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      refill_req_i,
    input  logic [`ICACHE_ADDR_W-1:0] refill_addr_i,
    output logic                      refill_beat_valid_o,
    output logic [`ICACHE_WORD_W-1:0] refill_beat_data_o,
    output logic                      refill_last_o,
    output logic                      refill_err_o,
    output logic                      axi_ar_valid_o,
    input  logic                      axi_ar_ready_i,
    output logic [`ICACHE_ADDR_W-1:0] axi_ar_addr_o,
    input  logic                      axi_r_valid_i,
    output logic                      axi_r_ready_o,
    input  logic [`ICACHE_WORD_W-1:0] axi_r_data_i,
    input  logic [1:0]                axi_r_resp_i,
    input  logic                      axi_r_last_i
);
    import icache_pkg::*;

    localparam int         CNT_W     = $clog2(`ICACHE_LINE_WORDS);
    localparam logic [7:0] BURST_LEN = 8'(`ICACHE_LINE_WORDS - 1);  // ar_len the slave expects
    localparam logic [1:0] RESP_OKAY = 2'b00;

    axi_rd_state_e             state_q, state_d;
    logic [`ICACHE_ADDR_W-1:0] addr_q;      // latched on the request
    logic [CNT_W-1:0]          beat_cnt_q;
    logic                      err_q;       // sticky over the burst
    logic                      beat;
    logic                      beat_bad;

    // next state of the read channel
    always_comb begin
        state_d = state_q;
        case (state_q)
            AXI_IDLE: begin
                if (refill_req_i)
                    state_d = AXI_ADDR_WAIT;
            end
            AXI_ADDR_WAIT: begin
                if (axi_ar_ready_i)
                    state_d = AXI_DATA_WAIT;  // ar handshake done
            end
            AXI_DATA_WAIT: begin
                if (beat && axi_r_last_i)
                    state_d = AXI_IDLE;
            end
            default: state_d = AXI_IDLE;
        endcase
    end

    assign beat = axi_r_valid_i && axi_r_ready_o;

    // error resp or r_last not where the burst length puts it
    assign beat_bad = (axi_r_resp_i != RESP_OKAY)
                    || (axi_r_last_i != (beat_cnt_q == BURST_LEN[CNT_W-1:0]));

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q    <= AXI_IDLE;
            beat_cnt_q <= '0;
            err_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == AXI_IDLE && refill_req_i) begin
                beat_cnt_q <= '0;  // fresh burst
                err_q      <= 1'b0;
            end else if (beat) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                err_q      <= err_q || beat_bad;
            end
        end
    end

    // line address held stable through ar_valid
    always_ff @(posedge clock) begin
        if (state_q == AXI_IDLE && refill_req_i)
            addr_q <= refill_addr_i;
    end

    assign axi_ar_valid_o = (state_q == AXI_ADDR_WAIT);
    assign axi_ar_addr_o  = addr_q;
    assign axi_r_ready_o  = (state_q == AXI_DATA_WAIT);

    // beats go straight through to the cache in the same cycle
    assign refill_beat_valid_o = beat;
    assign refill_beat_data_o  = axi_r_data_i;
    assign refill_last_o       = beat && axi_r_last_i;
    assign refill_err_o        = err_q || beat_bad;  // meaningful with last

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_top (
    input  logic                      clock,
    input  logic                      reset,
    // fetch port, four-phase
    input  logic                      fetch_req_i,
    input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
    output logic                      fetch_ack_o,
    output logic [`ICACHE_WORD_W-1:0] fetch_data_o,
    output logic                      fetch_err_o,
    // AXI read address channel
    output logic                      axi_ar_valid_o,
    input  logic                      axi_ar_ready_i,
    output logic [`ICACHE_ADDR_W-1:0] axi_ar_addr_o,
    // AXI read data channel
    input  logic                      axi_r_valid_i,
    output logic                      axi_r_ready_o,
    input  logic [`ICACHE_WORD_W-1:0] axi_r_data_i,
    input  logic [1:0]                axi_r_resp_i,
    input  logic                      axi_r_last_i
);
    // front end to cache
    logic                      lookup_valid;
    logic [`ICACHE_ADDR_W-1:0] lookup_addr;
    logic                      lookup_ready;
    logic                      lookup_done;
    logic [`ICACHE_WORD_W-1:0] lookup_data;
    logic                      lookup_err;

    // cache to AXI master
    logic                      refill_req;
    logic [`ICACHE_ADDR_W-1:0] refill_addr;
    logic                      refill_beat_valid;
    logic [`ICACHE_WORD_W-1:0] refill_beat_data;
    logic                      refill_last;
    logic                      refill_err;

    fetch_req_stage u_fetch (
        .clock          (clock),
        .reset          (reset),
        .fetch_req_i    (fetch_req_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ack_o    (fetch_ack_o),
        .fetch_data_o   (fetch_data_o),
        .fetch_err_o    (fetch_err_o),
        .lookup_valid_o (lookup_valid),
        .lookup_addr_o  (lookup_addr),
        .lookup_ready_i (lookup_ready),
        .lookup_done_i  (lookup_done),
        .lookup_data_i  (lookup_data),
        .lookup_err_i   (lookup_err)
    );

    icache_core u_core (
        .clock               (clock),
        .reset               (reset),
        .lookup_valid_i      (lookup_valid),
        .lookup_addr_i       (lookup_addr),
        .lookup_ready_o      (lookup_ready),
        .lookup_done_o       (lookup_done),
        .lookup_data_o       (lookup_data),
        .lookup_err_o        (lookup_err),
        .refill_req_o        (refill_req),
        .refill_addr_o       (refill_addr),
        .refill_beat_valid_i (refill_beat_valid),
        .refill_beat_data_i  (refill_beat_data),
        .refill_last_i       (refill_last),
        .refill_err_i        (refill_err)
    );

    axi_icache u_axi (
        .clock               (clock),
        .reset               (reset),
        .refill_req_i        (refill_req),
        .refill_addr_i       (refill_addr),
        .refill_beat_valid_o (refill_beat_valid),
        .refill_beat_data_o  (refill_beat_data),
        .refill_last_o       (refill_last),
        .refill_err_o        (refill_err),
        .axi_ar_valid_o      (axi_ar_valid_o),
        .axi_ar_ready_i      (axi_ar_ready_i),
        .axi_ar_addr_o       (axi_ar_addr_o),
        .axi_r_valid_i       (axi_r_valid_i),
        .axi_r_ready_o       (axi_r_ready_o),
        .axi_r_data_i        (axi_r_data_i),
        .axi_r_resp_i        (axi_r_resp_i),
        .axi_r_last_i        (axi_r_last_i)
    );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock_o,
    output logic reset_o
);
    initial begin
        clock_o = 1'b0;
        forever #10 clock_o = ~clock_o;  // 20 ns period
    end

    initial begin
        reset_o = 1'b0;      // low through the first two cycles
        #40 reset_o = 1'b1;  // released on a falling edge
    end

endmodule

//--- sim/icache_props.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_props (
    input logic                      clock_i,
    input logic                      reset_i,
    input logic                      fetch_req_i,
    input logic                      fetch_ack_i,
    input logic                      ar_valid_i,
    input logic                      ar_ready_i,
    input logic [`ICACHE_ADDR_W-1:0] ar_addr_i,
    input logic                      r_ready_i
);
    int fail_count = 0;  // assertion failures seen

    // address channel holds until accepted
    ar_hold: assert property (@(posedge clock_i) disable iff (!reset_i)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
        else begin
            $error("ar_valid dropped or ar_addr changed before ar_ready");
            fail_count++;
        end

    // r_ready only right after an ar handshake or while the burst runs
    r_after_ar: assert property (@(posedge clock_i) disable iff (!reset_i)
        r_ready_i |-> !ar_valid_i && ($past(r_ready_i) || $past(ar_valid_i && ar_ready_i)))
        else begin
            $error("r_ready high with ar_valid or without a preceding ar handshake");
            fail_count++;
        end

    ack_hold: assert property (@(posedge clock_i) disable iff (!reset_i)
        fetch_ack_i && fetch_req_i |=> fetch_ack_i)  // ack waits for req to fall
        else begin
            $error("fetch ack dropped while req still high");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clock_i)
        !reset_i |-> !fetch_ack_i && !ar_valid_i && !r_ready_i)
        else begin
            $error("ack, ar_valid or r_ready high during reset");
            fail_count++;
        end

endmodule

bind icache_top icache_props u_props (
    .clock_i     (clock),
    .reset_i     (reset),
    .fetch_req_i (fetch_req_i),
    .fetch_ack_i (fetch_ack_o),
    .ar_valid_i  (axi_ar_valid_o),
    .ar_ready_i  (axi_ar_ready_i),
    .ar_addr_i   (axi_ar_addr_o),
    .r_ready_i   (axi_r_ready_o)
);

//--- sim/tb_icache.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module tb_icache;
    localparam logic [31:0] PATTERN = 32'h5A5A5A5A;  // memory contents = address ^ pattern
    localparam int LINE_B  = `ICACHE_LINE_WORDS * 4;  // bytes per line
    localparam int IDX_LSB = $clog2(LINE_B);
    localparam int IDX_W   = $clog2(`ICACHE_LINES);

    logic                      clock;
    logic                      reset;
    logic                      fetch_req;
    logic [`ICACHE_ADDR_W-1:0] fetch_addr;
    logic                      fetch_ack;
    logic [`ICACHE_WORD_W-1:0] fetch_data;
    logic                      fetch_err;
    logic                      ar_valid;
    logic                      ar_ready;
    logic [`ICACHE_ADDR_W-1:0] ar_addr;
    logic                      r_valid;
    logic                      r_ready;
    logic [`ICACHE_WORD_W-1:0] r_data;
    logic [1:0]                r_resp;
    logic                      r_last;

    logic [31:0] addr_list [$];  // from the input file
    int          flag_list [$];
    int          hit_list [$];
    logic [15:0] lfsr = 16'd54000;
    logic        inject = 1'b0;  // error flag of the fetch in flight
    logic        loaded = 1'b0;
    int          n_lines = 0;
    int          ar_count = 0;
    int          beat_count = 0;
    logic [31:0] last_ar_addr = '0;
    int          n_fail = 0;   // wrong values
    int          n_other = 0;  // timeouts and file trouble
    logic        model_valid [`ICACHE_LINES];
    logic [31:0] model_tag [`ICACHE_LINES];

    tb_clock_gen u_clk (
        .clock_o (clock),
        .reset_o (reset)
    );

    icache_top dut (
        .clock          (clock),
        .reset          (reset),
        .fetch_req_i    (fetch_req),
        .fetch_addr_i   (fetch_addr),
        .fetch_ack_o    (fetch_ack),
        .fetch_data_o   (fetch_data),
        .fetch_err_o    (fetch_err),
        .axi_ar_valid_o (ar_valid),
        .axi_ar_ready_i (ar_ready),
        .axi_ar_addr_o  (ar_addr),
        .axi_r_valid_i  (r_valid),
        .axi_r_ready_o  (r_ready),
        .axi_r_data_i   (r_data),
        .axi_r_resp_i   (r_resp),
        .axi_r_last_i   (r_last)
    );

    // galois lfsr x^16+x^14+x^13+x^11+1, one step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // AXI memory, one INCR burst per AR
    initial begin : axi_mem
        int          delay;
        logic [31:0] base;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        r_resp   = 2'b00;
        r_last   = 1'b0;
        forever begin
            @(negedge clock);
            if (ar_valid) begin
                delay = rand_bits(2);  // 0..3 cycles
                repeat (delay) @(negedge clock);
                base     = ar_addr;
                ar_ready = 1'b1;
                @(negedge clock);  // handshake on the edge between
                ar_ready     = 1'b0;
                ar_count++;
                last_ar_addr = base;
                for (int k = 0; k < `ICACHE_LINE_WORDS; k++) begin
                    delay = rand_bits(2) % 3;  // r_valid gap 0..2
                    repeat (delay) @(negedge clock);
                    r_valid = 1'b1;
                    r_data  = (base + 32'(4 * k)) ^ PATTERN;
                    r_resp  = inject ? 2'b10 : 2'b00;  // SLVERR on every beat
                    r_last  = (k == `ICACHE_LINE_WORDS - 1);
                    while (!r_ready) @(negedge clock);
                    @(negedge clock);  // beat taken
                    beat_count++;
                    r_valid = 1'b0;
                    r_last  = 1'b0;
                end
            end
        end
    end

    // ack may only rise on an edge that saw req high
    initial begin : ack_monitor
        logic ack_prev;
        logic req_prev;
        ack_prev = 1'b0;
        req_prev = 1'b0;
        forever begin
            @(posedge clock);
            if (fetch_ack && !ack_prev && !req_prev) begin
                $display("%0t: fetch_ack_o rose while fetch_req_i was low", $time);
                n_other++;
            end
            ack_prev = fetch_ack;
            req_prev = fetch_req;
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (n_lines * 200 + 100) @(posedge clock);
        $display("watchdog: run exceeded %0d clock periods", n_lines * 200 + 100);
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        int               fd;
        int               e;
        int               h;
        int               idx;
        int               cycles;
        int               ar_before;
        int               beats_before;
        logic [31:0]      a;
        logic [31:0]      tag;
        logic [31:0]      expect_data;
        logic             hit;
        logic             exp_err;
        logic [8*100-1:0] line_buf;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        foreach (model_valid[j])
            model_valid[j] = 1'b0;  // empty after reset
        fd = $fopen("sim/fetch_input.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/fetch_input.txt");
            n_other++;
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                if ($fgets(line_buf, fd) > 0 && $sscanf(line_buf, "%h %d %d", a, e, h) == 3) begin
                    addr_list.push_back(a);  // comment lines do not parse
                    flag_list.push_back(e);
                    hit_list.push_back(h);
                end
            end
            $fclose(fd);
        end
        n_lines = addr_list.size();
        if (n_lines == 0) begin
            $display("no fetches found in sim/fetch_input.txt");
            n_other++;
        end
        loaded = 1'b1;
        @(posedge reset);
        @(negedge clock);

        foreach (addr_list[i]) begin
            a   = addr_list[i];
            idx = int'(a[IDX_LSB +: IDX_W]);
            tag = a >> (IDX_LSB + IDX_W);
            hit = model_valid[idx] && (model_tag[idx] == tag);  // predicted from addresses only
            if (int'(hit) != hit_list[i]) begin
                $display("fetch %0d: input file says hit=%0d, cache model says %0d",
                         i, hit_list[i], hit);
                n_other++;
            end
            inject       = (flag_list[i] != 0);
            exp_err      = inject && !hit;
            expect_data  = {a[31:2], 2'b00} ^ PATTERN;
            ar_before    = ar_count;
            beats_before = beat_count;
            fetch_addr   = a;
            fetch_req    = 1'b1;
            cycles       = 0;
            while (!fetch_ack && cycles < 200) begin
                @(negedge clock);
                cycles++;
            end
            if (!fetch_ack) begin
                $display("%0t: no fetch_ack_o for address %h within 200 cycles", $time, a);
                n_other++;
            end else begin
                if (hit && cycles - 1 != 3) begin  // counted from the sampling edge
                    $display("[FAIL] %0t fetch_ack_o latency: expected 3, got %0d",
                             $time, cycles - 1);
                    n_fail++;
                end
                if (fetch_err != exp_err) begin
                    $display("[FAIL] %0t fetch_err_o: expected %b, got %b",
                             $time, exp_err, fetch_err);
                    n_fail++;
                end
                if (!exp_err && fetch_data != expect_data) begin
                    $display("[FAIL] %0t fetch_data_o: expected %h, got %h",
                             $time, expect_data, fetch_data);
                    n_fail++;
                end
                if (ar_count - ar_before != (hit ? 0 : 1)) begin
                    $display("[FAIL] %0t AR handshakes: expected %0d, got %0d",
                             $time, hit ? 0 : 1, ar_count - ar_before);
                    n_fail++;
                end
                if (!hit && last_ar_addr != (a & ~32'(LINE_B - 1))) begin
                    $display("[FAIL] %0t axi_ar_addr_o: expected %h, got %h",
                             $time, a & ~32'(LINE_B - 1), last_ar_addr);
                    n_fail++;
                end
                if (beat_count - beats_before != (hit ? 0 : `ICACHE_LINE_WORDS)) begin
                    $display("[FAIL] %0t R beats: expected %0d, got %0d",
                             $time, hit ? 0 : `ICACHE_LINE_WORDS, beat_count - beats_before);
                    n_fail++;
                end
            end
            if (!hit) begin
                model_valid[idx] = !exp_err;  // bad burst leaves the line invalid
                model_tag[idx]   = tag;
            end

            fetch_req = 1'b0;
            cycles    = 0;
            while (fetch_ack && cycles < 20) begin
                @(negedge clock);
                cycles++;
            end
            if (fetch_ack) begin
                $display("%0t: fetch_ack_o stayed high after fetch_req_i fell", $time);
                n_other++;
            end else if (cycles != 2) begin
                $display("[FAIL] %0t fetch_ack_o release: expected 2 falling edges, got %0d",
                         $time, cycles);
                n_fail++;
            end
        end

        $display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
                 n_fail, n_other, dut.u_props.fail_count);
        if (n_fail + n_other + dut.u_props.fail_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- sim/fetch_input.txt
# columns: fetch byte address (hex), error inject flag, expected hit flag
# lines 16 bytes, index = addr[7:4], tag = addr[31:8]
00001000 0 0
00001004 0 1
0000100C 0 1
00001010 0 0
00001018 0 1
00002000 0 0
00001008 0 0
00002004 0 0
00003040 1 0
00003044 0 0
00003048 0 1
000030F0 0 0
000030FC 0 1
00001014 0 1
00004004 0 0
00002008 0 0
00005F80 1 0
00005F84 1 0
00005F8C 0 0
00005F88 0 1

//--- all.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/fetch_req_stage.sv
verilog/icache_core.sv
verilog/axi_icache.sv
verilog/icache_top.sv
sim/tb_clock_gen.sv
sim/icache_props.sv
sim/tb_icache.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_icache -o sim_icache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_icache +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
fi
exit 1
